// File: verification/bridge_patterns.txt
// columns: op key addr data expect, all hex
// op 1 write, 2 read, 3 set keys, 4 hold keys for data frames,
// 5 frame check, 6 frame count step, 7 end of test data, ff stop
// test 1, reset values and read back
2 0 00200000 0 87
2 0 00200004 0 5F
2 0 00F0000C 0 7
2 0 00100000 0 1
2 0 00100004 0 12005678
2 0 00300000 0 0
2 0 00500000 0 0
1 0 00100004 CAFE0001 0
2 0 00100004 0 CAFE0001
1 0 00300000 A5A5F00F 0
2 0 00300000 0 A5A5F00F
1 0 00F0000C 5 0
2 0 00F0000C 0 5
1 0 00F0000C 7 0
1 0 00100000 0 0
2 0 00100000 0 0
1 0 00100000 1 0
2 0 00100000 0 1
7 0 0 1 0
// tests 2 and 3, timing and clear frame
5 0 0 0 0
7 0 0 2 0
// test 4, cells and channel mask
1 0 00400000 00010C03 0
1 0 00400000 00010E14 0
1 0 00400000 00010000 0
1 0 00400000 00011D27 0
1 0 00400000 00011E00 0
5 0 0 0 0
1 0 00F0000C 4 0
5 0 0 0 0
1 0 00F0000C 7 0
7 0 0 4 0
// test 5, square placement, keys and colours
1 0 00200000 14 0
1 0 00200004 0 0
2 0 00200000 0 14
2 0 00200004 0 0
5 0 0 0 0
4 1 0 2 0
2 0 00200004 0 0
4 8 0 3 0
2 0 00200000 0 17
5 0 0 0 0
1 0 00F00010 1 0
2 0 00200000 0 87
2 0 00200004 0 5F
3 10 0 0 0
5 0 0 0 0
3 20 0 0 0
5 0 0 0 0
3 0 0 0 0
7 0 0 5 0
// test 6, frame counter
6 0 0 0 1
1 0 00100000 0 0
6 0 0 0 0
1 0 00F00014 1 0
2 0 20000000 0 0
1 0 00F00018 1 0
2 0 20000000 0 1
1 0 00100000 1 0
7 0 0 6 0
ff 0 0 0 0

// File: flist.f
verilog/video_pkg.sv
verilog/bridge_regs.sv
verilog/frame_timing.sv
verilog/square_ctrl.sv
verilog/cell_grid.sv
verilog/pixel_mixer.sv
verilog/pattern_core.sv
verification/tb_pattern_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pattern core testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_pattern_core -o tb_pattern_core
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_pattern_core > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation passed$" "$log"; then
	exit 0
fi
exit 1

// File: verification/tb_pattern_core.sv
//////////////////////////////////////////////////
// pattern core testbench
// runs bridge operations from a pattern file and
// checks registers, frame timing and every pixel
//////////////////////////////////////////////////

module tb_pattern_core
	import video_pkg::*;
();

	// default video geometry of the DUT
	localparam int h_active = 320;
	localparam int h_total = 400;
	localparam int v_active = 240;
	localparam int v_total = 512;
	localparam int square_size = 50;
	localparam int centre_x = (h_active - square_size) / 2;
	localparam int centre_y = (v_active - square_size) / 2;
	localparam int max_x = h_active - square_size;
	localparam int max_y = v_active - square_size;
	localparam int pattern_words = 512;
	// a bit more than one frame of cycles
	localparam int wait_limit = 300000;

	logic clk_74a;
	logic reset_n;
	logic [31:0] bridge_addr;
	logic bridge_rd;
	logic [31:0] bridge_rd_data;
	logic bridge_wr;
	logic [31:0] bridge_wr_data;
	logic [15:0] cont1_key;
	rgb_t video_rgb;
	logic video_de;
	logic video_hs;
	logic video_vs;

	// five words per entry: op, key, addr, data, expect
	logic [31:0] patterns [0:pattern_words-1];

	// reference state kept by the testbench
	int exp_x;
	int exp_y;
	logic [2:0] exp_chan;
	logic exp_cells [0:grid_cells-1];
	int pass_count;
	int fail_count;
	int test_fails;
	logic timed_out;

	always #4 clk_74a = ~clk_74a;

	pattern_core UUT (
		.clk_74a        (clk_74a),
		.reset_n        (reset_n),
		.bridge_addr    (bridge_addr),
		.bridge_rd      (bridge_rd),
		.bridge_rd_data (bridge_rd_data),
		.bridge_wr      (bridge_wr),
		.bridge_wr_data (bridge_wr_data),
		.cont1_key      (cont1_key),
		.video_rgb      (video_rgb),
		.video_de       (video_de),
		.video_hs       (video_hs),
		.video_vs       (video_vs)
	);

	//////////////////////////////////////////////////
	// reference pixel, square over borders over grid
	function automatic rgb_t expected_pixel(input int x, input int y);
		rgb_t c;
		logic in_sq;
		logic ring;
		in_sq = (x >= exp_x) && (x < exp_x + square_size)
			&& (y >= exp_y) && (y < exp_y + square_size);
		ring = (x == exp_x) || (x == exp_x + square_size - 1)
			|| (y == exp_y) || (y == exp_y + square_size - 1);
		if (in_sq && ring) begin
			c = black;
		end else if (in_sq) begin
			if (cont1_key[key_a]) c = magenta;
			else if (cont1_key[key_b]) c = green;
			else c = white;
		end else if (x == 0) begin
			c = white;
		end else if (x == h_active - 1) begin
			c = green;
		end else if (y == 0) begin
			c = red;
		end else if (y == v_active - 1) begin
			c = blue;
		end else begin
			c = exp_cells[(y / 8) * grid_cols + x / 8] ? white : black;
		end
		// masked channels read zero
		return {c[23:16] & {8{exp_chan[2]}}, c[15:8] & {8{exp_chan[1]}},
			c[7:0] & {8{exp_chan[0]}}};
	endfunction

	// track what a host write should do
	function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
		int row;
		int col;
		row = int'(data[15:8]);
		col = int'(data[7:0]);
		case (addr)
			addr_square_x: exp_x = int'(data[9:0]);
			addr_square_y: exp_y = int'(data[9:0]);
			addr_chan_en: exp_chan = data[2:0];
			addr_reset_square: begin
				exp_x = centre_x;
				exp_y = centre_y;
			end
			addr_cell_write: begin
				if (row < grid_rows && col < grid_cols) begin
					exp_cells[row * grid_cols + col] = data[16];
				end
			end
			default: ;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) begin
			pass_count++;
		end else begin
			$display("mismatch at %0t: %s read %h, expected %h", $time, what, got, expected);
			fail_count++;
		end
	endtask

	// returns on the negedge inside the vs cycle
	task automatic wait_vs();
		int n;
		n = 0;
		do begin
			@(negedge clk_74a);
			n++;
		end while (!video_vs && n < wait_limit);
		if (!video_vs) begin
			$display("timeout while waiting for video_vs");
			timed_out = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////
	// bridge access
	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk_74a);
		bridge_addr <= addr;
		bridge_wr_data <= data;
		bridge_wr <= 1'b1;
		@(posedge clk_74a);
		bridge_wr <= 1'b0;
		model_write(addr, data);
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
		@(posedge clk_74a);
		bridge_addr <= addr;
		bridge_rd <= 1'b1;
		@(posedge clk_74a);
		bridge_rd <= 1'b0;
		// one cycle latency, settled by the falling edge
		@(negedge clk_74a);
		data = bridge_rd_data;
	endtask

	// keys change just after vs, so each counted frame steps once
	task automatic hold_keys(input logic [15:0] keys, input int frames);
		wait_vs();
		if (timed_out) return;
		@(posedge clk_74a);
		cont1_key <= keys;
		repeat (frames) begin
			wait_vs();
			if (timed_out) return;
			if (keys[key_left] && exp_x > 0) exp_x--;
			if (keys[key_right] && exp_x < max_x) exp_x++;
			if (keys[key_up] && exp_y > 0) exp_y--;
			if (keys[key_down] && exp_y < max_y) exp_y++;
		end
		@(posedge clk_74a);
		cont1_key <= '0;
	endtask

	task automatic frame_step(input logic [31:0] expected);
		logic [31:0] c0;
		logic [31:0] c1;
		wait_vs();
		if (timed_out) return;
		bus_read(addr_frame_count, c0);
		wait_vs();
		if (timed_out) return;
		bus_read(addr_frame_count, c1);
		check_value("frame_count step", c1 - c0, expected);
	endtask

	//////////////////////////////////////////////////
	// one full frame, vs to vs
	task automatic check_frame();
		int cycles;
		int lines;
		int hs_count;
		int run;
		rgb_t exp_rgb;
		wait_vs();
		if (timed_out) return;
		cycles = 0;
		lines = 0;
		hs_count = 0;
		run = 0;
		do begin
			@(negedge clk_74a);
			cycles++;
			if (video_hs) hs_count++;
			if (video_de) begin
				exp_rgb = expected_pixel(run, lines);
				assert (video_rgb === exp_rgb) begin
					pass_count++;
				end else begin
					$display("mismatch at %0t: pixel %0d,%0d is %h, expected %h",
						$time, run, lines, video_rgb, exp_rgb);
					fail_count++;
				end
				run++;
			end else if (run != 0) begin
				check_value("de cycles in line", run, h_active);
				lines++;
				run = 0;
			end
		end while (!video_vs && cycles < wait_limit);
		if (!video_vs) begin
			$display("timeout, frame did not end with video_vs");
			timed_out = 1'b1;
			return;
		end
		check_value("cycles between vs pulses", cycles, h_total * v_total);
		check_value("active lines", lines, v_active);
		check_value("hs pulses per frame", hs_count, v_total);
	endtask

	//////////////////////////////////////////////////
	// pattern sequencer
	initial begin
		int idx;
		logic running;
		logic [31:0] op;
		logic [31:0] rd;
		clk_74a = 1'b0;
		reset_n = 1'b0;
		bridge_addr = '0;
		bridge_rd = 1'b0;
		bridge_wr = 1'b0;
		bridge_wr_data = '0;
		cont1_key = '0;
		exp_x = centre_x;
		exp_y = centre_y;
		exp_chan = 3'b111;
		for (int i = 0; i < grid_cells; i++) exp_cells[i] = 1'b0;
		pass_count = 0;
		fail_count = 0;
		test_fails = 0;
		timed_out = 1'b0;
		$readmemh("verification/bridge_patterns.txt", patterns);
		repeat (2) @(posedge clk_74a);
		reset_n <= 1'b1;
		idx = 0;
		running = 1'b1;
		while (running && !timed_out && idx + 4 < pattern_words) begin
			op = patterns[idx];
			case (op)
				32'h1: bus_write(patterns[idx+2], patterns[idx+3]);
				32'h2: begin
					bus_read(patterns[idx+2], rd);
					check_value($sformatf("register %h", patterns[idx+2]), rd, patterns[idx+4]);
				end
				32'h3: begin
					@(posedge clk_74a);
					cont1_key <= patterns[idx+1][15:0];
				end
				32'h4: hold_keys(patterns[idx+1][15:0], int'(patterns[idx+3]));
				32'h5: check_frame();
				32'h6: frame_step(patterns[idx+4]);
				32'h7: begin
					$display("test %0d finished with %0d failed checks",
						patterns[idx+3], fail_count - test_fails);
					test_fails = fail_count;
				end
				32'hff: running = 1'b0;
				default: begin
					$display("pattern file holds an unknown operation %h", op);
					fail_count++;
					running = 1'b0;
				end
			endcase
			idx += 5;
		end
		$display("checks passed %0d, checks failed %0d", pass_count, fail_count);
		if (fail_count == 0 && !timed_out) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: verilog/pattern_core.sv
//////////////////////////////////////////////////
// test pattern video core
// bridge registers, timing, movable square and
// cell grid mixed into one video stream
//////////////////////////////////////////////////

module pattern_core
	import video_pkg::*;
#(
	parameter int h_active = 320,
	parameter int h_total = 400,
	parameter int v_active = 240,
	parameter int v_total = 512,
	parameter int porch = 10,
	parameter int square_size = 50
) (
	input  logic        clk_74a,
	input  logic        reset_n,
	input  logic [31:0] bridge_addr,
	input  logic        bridge_rd,
	output logic [31:0] bridge_rd_data,
	input  logic        bridge_wr,
	input  logic [31:0] bridge_wr_data,
	input  logic [15:0] cont1_key,
	output rgb_t        video_rgb,
	output logic        video_de,
	output logic        video_hs,
	output logic        video_vs
);

	// register file outputs
	logic [2:0] chan_en;
	logic anim_en;
	logic square_x_load;
	logic square_y_load;
	coord_t new_x;
	coord_t new_y;
	logic square_reset;
	logic frame_reset;
	logic frame_incr;
	logic cell_we;
	cell_addr_t cell_waddr;
	logic cell_wdata;

	// timing and position
	coord_t visible_x;
	coord_t visible_y;
	logic active;
	logic line_start;
	logic frame_start;
	logic [15:0] frame_count;
	coord_t square_x;
	coord_t square_y;

	// grid read path
	cell_addr_t rd_addr;
	logic cell_state;

	bridge_regs u_bridge_regs (
		.clk_74a        (clk_74a),
		.reset_n        (reset_n),
		.bridge_addr    (bridge_addr),
		.bridge_rd      (bridge_rd),
		.bridge_wr      (bridge_wr),
		.bridge_wr_data (bridge_wr_data),
		.square_x       (square_x),
		.square_y       (square_y),
		.frame_count    (frame_count),
		.bridge_rd_data (bridge_rd_data),
		.chan_en        (chan_en),
		.anim_en        (anim_en),
		.square_x_load  (square_x_load),
		.square_y_load  (square_y_load),
		.new_x          (new_x),
		.new_y          (new_y),
		.square_reset   (square_reset),
		.frame_reset    (frame_reset),
		.frame_incr     (frame_incr),
		.cell_we        (cell_we),
		.cell_waddr     (cell_waddr),
		.cell_wdata     (cell_wdata)
	);

	frame_timing #(
		.h_active (h_active),
		.h_total  (h_total),
		.v_active (v_active),
		.v_total  (v_total),
		.porch    (porch)
	) u_frame_timing (
		.clk_74a     (clk_74a),
		.reset_n     (reset_n),
		.anim_en     (anim_en),
		.frame_reset (frame_reset),
		.frame_incr  (frame_incr),
		.visible_x   (visible_x),
		.visible_y   (visible_y),
		.active      (active),
		.line_start  (line_start),
		.frame_start (frame_start),
		.frame_count (frame_count)
	);

	square_ctrl #(
		.h_active    (h_active),
		.v_active    (v_active),
		.square_size (square_size)
	) u_square_ctrl (
		.clk_74a       (clk_74a),
		.reset_n       (reset_n),
		.cont1_key     (cont1_key),
		.frame_start   (frame_start),
		.square_x_load (square_x_load),
		.square_y_load (square_y_load),
		.new_x         (new_x),
		.new_y         (new_y),
		.square_reset  (square_reset),
		.square_x      (square_x),
		.square_y      (square_y)
	);

	cell_grid u_cell_grid (
		.clk_74a    (clk_74a),
		.reset_n    (reset_n),
		.cell_we    (cell_we),
		.cell_waddr (cell_waddr),
		.cell_wdata (cell_wdata),
		.rd_addr    (rd_addr),
		.cell_state (cell_state)
	);

	pixel_mixer #(
		.h_active    (h_active),
		.v_active    (v_active),
		.square_size (square_size)
	) u_pixel_mixer (
		.clk_74a     (clk_74a),
		.reset_n     (reset_n),
		.visible_x   (visible_x),
		.visible_y   (visible_y),
		.active      (active),
		.line_start  (line_start),
		.frame_start (frame_start),
		.square_x    (square_x),
		.square_y    (square_y),
		.cont1_key   (cont1_key),
		.chan_en     (chan_en),
		.cell_state  (cell_state),
		.rd_addr     (rd_addr),
		.video_rgb   (video_rgb),
		.video_de    (video_de),
		.video_hs    (video_hs),
		.video_vs    (video_vs)
	);

endmodule

// File: verilog/pixel_mixer.sv
//////////////////////////////////////////////////
// pixel mixer
// square, debug borders and grid by priority,
// then channel mask, two register stages deep
//////////////////////////////////////////////////

module pixel_mixer
	import video_pkg::*;
#(
	parameter int h_active = 320,
	parameter int v_active = 240,
	parameter int square_size = 50
) (
	input  logic        clk_74a,
	input  logic        reset_n,
	input  coord_t      visible_x,
	input  coord_t      visible_y,
	input  logic        active,
	input  logic        line_start,
	input  logic        frame_start,
	input  coord_t      square_x,
	input  coord_t      square_y,
	input  logic [15:0] cont1_key,
	input  logic [2:0]  chan_en,
	input  logic        cell_state,
	output cell_addr_t  rd_addr,
	output rgb_t        video_rgb,
	output logic        video_de,
	output logic        video_hs,
	output logic        video_vs
);

	// stage 1, lined up with the grid read
	coord_t x_d;
	coord_t y_d;
	logic de_d;
	logic hs_d;
	logic vs_d;
	// square bounds, 11 bits so a far host placement cannot wrap
	logic [10:0] sq_x_end;
	logic [10:0] sq_y_end;
	logic in_square;
	logic in_inner;
	rgb_t layer_rgb;
	rgb_t masked_rgb;

	assign rd_addr = cell_addr_t'(visible_y >> cell_shift) * cell_addr_t'(grid_cols)
		+ cell_addr_t'(visible_x >> cell_shift);

	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			de_d <= 1'b0;
			hs_d <= 1'b0;
			vs_d <= 1'b0;
		end else begin
			de_d <= active;
			hs_d <= line_start;
			vs_d <= frame_start;
		end
	end

	always_ff @(posedge clk_74a) begin
		x_d <= visible_x;
		y_d <= visible_y;
	end

	//////////////////////////////////////////////////
	// stage 2, layer select
	assign sq_x_end = 11'(square_x) + 11'(square_size);
	assign sq_y_end = 11'(square_y) + 11'(square_size);
	assign in_square = (x_d >= square_x) && (11'(x_d) < sq_x_end)
		&& (y_d >= square_y) && (11'(y_d) < sq_y_end);
	// interior is the square less its one pixel ring
	assign in_inner = (11'(x_d) > 11'(square_x)) && (11'(x_d) + 11'd1 < sq_x_end)
		&& (11'(y_d) > 11'(square_y)) && (11'(y_d) + 11'd1 < sq_y_end);

	always_comb begin
		if (in_square && !in_inner) begin
			layer_rgb = black;
		end else if (in_square) begin
			// face buttons recolour the interior
			if (cont1_key[key_a]) layer_rgb = magenta;
			else if (cont1_key[key_b]) layer_rgb = green;
			else layer_rgb = white;
		end else if (x_d == '0) begin
			layer_rgb = white;
		end else if (x_d == coord_t'(h_active - 1)) begin
			layer_rgb = green;
		end else if (y_d == '0) begin
			layer_rgb = red;
		end else if (y_d == coord_t'(v_active - 1)) begin
			layer_rgb = blue;
		end else begin
			layer_rgb = cell_state ? white : black;
		end
	end

	// chan_en bit 2 is red, bit 0 is blue
	assign masked_rgb = {layer_rgb[23:16] & {8{chan_en[2]}},
		layer_rgb[15:8] & {8{chan_en[1]}},
		layer_rgb[7:0] & {8{chan_en[0]}}};

	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			video_rgb <= black;
			video_de <= 1'b0;
			video_hs <= 1'b0;
			video_vs <= 1'b0;
		end else begin
			// blanking is always black
			video_rgb <= de_d ? masked_rgb : black;
			video_de <= de_d;
			video_hs <= hs_d;
			video_vs <= vs_d;
		end
	end

endmodule

// File: verilog/cell_grid.sv
//////////////////////////////////////////////////
// cell grid memory
// one bit per 8x8 cell, wiped after reset, host
// write port and a synchronous pixel read port
//////////////////////////////////////////////////

module cell_grid
	import video_pkg::*;
(
	input  logic       clk_74a,
	input  logic       reset_n,
	input  logic       cell_we,
	input  cell_addr_t cell_waddr,
	input  logic       cell_wdata,
	input  cell_addr_t rd_addr,
	output logic       cell_state
);

	logic mem [0:grid_cells-1];

	// clear sequencer state
	logic clr_busy;
	cell_addr_t clr_addr;

	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			clr_busy <= 1'b1;
			clr_addr <= '0;
		end else if (clr_busy) begin
			// one cell per cycle, stop after the last
			if (clr_addr == cell_addr_t'(grid_cells - 1)) clr_busy <= 1'b0;
			clr_addr <= clr_addr + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// memory ports
	always_ff @(posedge clk_74a) begin
		// host writes are lost while clearing
		if (clr_busy) begin
			mem[clr_addr] <= 1'b0;
		end else if (cell_we && cell_waddr < cell_addr_t'(grid_cells)) begin
			mem[cell_waddr] <= cell_wdata;
		end
		// addresses past the grid read as clear
		if (rd_addr < cell_addr_t'(grid_cells)) begin
			cell_state <= mem[rd_addr];
		end else begin
			cell_state <= 1'b0;
		end
	end

endmodule

// File: verilog/square_ctrl.sv
//////////////////////////////////////////////////
// square position control
// d-pad steps once per frame within the active
// area, host can place it or send it to centre
//////////////////////////////////////////////////

module square_ctrl
	import video_pkg::*;
#(
	parameter int h_active = 320,
	parameter int v_active = 240,
	parameter int square_size = 50
) (
	input  logic        clk_74a,
	input  logic        reset_n,
	input  logic [15:0] cont1_key,
	input  logic        frame_start,
	input  logic        square_x_load,
	input  logic        square_y_load,
	input  coord_t      new_x,
	input  coord_t      new_y,
	input  logic        square_reset,
	output coord_t      square_x,
	output coord_t      square_y
);

	localparam coord_t max_x = coord_t'(h_active - square_size);
	localparam coord_t max_y = coord_t'(v_active - square_size);
	localparam coord_t centre_x = coord_t'((h_active - square_size) / 2);
	localparam coord_t centre_y = coord_t'((v_active - square_size) / 2);

	coord_t step_x;
	coord_t step_y;

	// next position if this were a frame_start cycle
	// right and down win when opposite keys are held
	always_comb begin
		step_x = square_x;
		step_y = square_y;
		if (cont1_key[key_left] && square_x > '0) step_x = square_x - 1'b1;
		if (cont1_key[key_right] && square_x < max_x) step_x = square_x + 1'b1;
		if (cont1_key[key_up] && square_y > '0) step_y = square_y - 1'b1;
		if (cont1_key[key_down] && square_y < max_y) step_y = square_y + 1'b1;
	end

	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			square_x <= centre_x;
			square_y <= centre_y;
		end else if (square_reset) begin
			square_x <= centre_x;
			square_y <= centre_y;
		end else begin
			// host load is taken as is, no clamp
			if (square_x_load) square_x <= new_x;
			else if (frame_start) square_x <= step_x;
			if (square_y_load) square_y <= new_y;
			else if (frame_start) square_y <= step_y;
		end
	end

endmodule

// File: verilog/frame_timing.sv
//////////////////////////////////////////////////
// frame timing generator
// pixel and line counters, sync strobes, active
// window and the host visible frame counter
//////////////////////////////////////////////////

module frame_timing
	import video_pkg::*;
#(
	parameter int h_active = 320,
	parameter int h_total = 400,
	parameter int v_active = 240,
	parameter int v_total = 512,
	parameter int porch = 10
) (
	input  logic        clk_74a,
	input  logic        reset_n,
	input  logic        anim_en,
	input  logic        frame_reset,
	input  logic        frame_incr,
	output coord_t      visible_x,
	output coord_t      visible_y,
	output logic        active,
	output logic        line_start,
	output logic        frame_start,
	output logic [15:0] frame_count
);

	coord_t x_count;
	coord_t y_count;
	logic h_window;
	logic v_window;
	// up to two increments can land in one cycle
	logic [1:0] frame_step;

	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			x_count <= '0;
			y_count <= '0;
		end else if (x_count == coord_t'(h_total - 1)) begin
			x_count <= '0;
			y_count <= (y_count == coord_t'(v_total - 1)) ? '0 : y_count + 1'b1;
		end else begin
			x_count <= x_count + 1'b1;
		end
	end

	// hs a few pixels after vs, both in the back porch
	assign frame_start = (x_count == '0) && (y_count == '0);
	assign line_start = (x_count == coord_t'(3));

	assign h_window = (x_count >= coord_t'(porch)) && (x_count < coord_t'(porch + h_active));
	assign v_window = (y_count >= coord_t'(porch)) && (y_count < coord_t'(porch + v_active));
	assign active = h_window && v_window;

	// wraps outside the window, only meaningful when active
	assign visible_x = x_count - coord_t'(porch);
	assign visible_y = y_count - coord_t'(porch);

	//////////////////////////////////////////////////
	// frame counter
	assign frame_step = 2'(frame_incr) + 2'(frame_start && anim_en);

	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			frame_count <= '0;
		end else if (frame_reset) begin
			frame_count <= '0;
		end else begin
			frame_count <= frame_count + 16'(frame_step);
		end
	end

endmodule

// File: verilog/bridge_regs.sv
//////////////////////////////////////////////////
// bridge register file
// host writes land in registers or one-cycle
// command pulses, reads come back a cycle later
//////////////////////////////////////////////////

module bridge_regs
	import video_pkg::*;
(
	input  logic        clk_74a,
	input  logic        reset_n,
	input  logic [31:0] bridge_addr,
	input  logic        bridge_rd,
	input  logic        bridge_wr,
	input  logic [31:0] bridge_wr_data,
	input  coord_t      square_x,
	input  coord_t      square_y,
	input  logic [15:0] frame_count,
	output logic [31:0] bridge_rd_data,
	output logic [2:0]  chan_en,
	output logic        anim_en,
	output logic        square_x_load,
	output logic        square_y_load,
	output coord_t      new_x,
	output coord_t      new_y,
	output logic        square_reset,
	output logic        frame_reset,
	output logic        frame_incr,
	output logic        cell_we,
	output cell_addr_t  cell_waddr,
	output logic        cell_wdata
);

	logic [31:0] debug_value;
	logic [31:0] scratch_value;
	// cell write word: [16] value, [15:8] row, [7:0] column
	logic [7:0] wr_row;
	logic [7:0] wr_col;
	logic cell_in_range;

	assign wr_row = bridge_wr_data[15:8];
	assign wr_col = bridge_wr_data[7:0];
	assign cell_in_range = (wr_row < 8'(grid_rows)) && (wr_col < 8'(grid_cols));

	//////////////////////////////////////////////////
	// write decode
	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			chan_en <= 3'b111;
			anim_en <= 1'b1;
			debug_value <= debug_reset_value;
			scratch_value <= '0;
			square_x_load <= 1'b0;
			square_y_load <= 1'b0;
			square_reset <= 1'b0;
			frame_reset <= 1'b0;
			frame_incr <= 1'b0;
			cell_we <= 1'b0;
		end else begin
			// pulses drop after one cycle
			square_x_load <= 1'b0;
			square_y_load <= 1'b0;
			square_reset <= 1'b0;
			frame_reset <= 1'b0;
			frame_incr <= 1'b0;
			cell_we <= 1'b0;
			if (bridge_wr) begin
				case (bridge_addr)
					addr_square_x: square_x_load <= 1'b1;
					addr_square_y: square_y_load <= 1'b1;
					addr_chan_en: chan_en <= bridge_wr_data[2:0];
					addr_anim_en: anim_en <= bridge_wr_data[0];
					addr_debug: debug_value <= bridge_wr_data;
					addr_scratch: scratch_value <= bridge_wr_data;
					addr_reset_square: square_reset <= 1'b1;
					addr_reset_frame: frame_reset <= 1'b1;
					addr_incr_frame: frame_incr <= 1'b1;
					// out of range cells are ignored
					addr_cell_write: cell_we <= cell_in_range;
					default: ;
				endcase
			end
		end
	end

	// data that travels with the pulses
	always_ff @(posedge clk_74a) begin
		if (bridge_wr && bridge_addr == addr_square_x) begin
			new_x <= coord_t'(bridge_wr_data);
		end
		if (bridge_wr && bridge_addr == addr_square_y) begin
			new_y <= coord_t'(bridge_wr_data);
		end
		if (bridge_wr && bridge_addr == addr_cell_write) begin
			// row major linear index
			cell_waddr <= cell_addr_t'(wr_row) * cell_addr_t'(grid_cols)
				+ cell_addr_t'(wr_col);
			cell_wdata <= bridge_wr_data[16];
		end
	end

	//////////////////////////////////////////////////
	// read mux, one cycle latency
	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			bridge_rd_data <= '0;
		end else if (bridge_rd) begin
			case (bridge_addr)
				addr_square_x: bridge_rd_data <= 32'(square_x);
				addr_square_y: bridge_rd_data <= 32'(square_y);
				addr_chan_en: bridge_rd_data <= 32'(chan_en);
				addr_anim_en: bridge_rd_data <= 32'(anim_en);
				addr_debug: bridge_rd_data <= debug_value;
				addr_scratch: bridge_rd_data <= scratch_value;
				addr_frame_count: bridge_rd_data <= 32'(frame_count);
				// unmapped and write-only addresses
				default: bridge_rd_data <= '0;
			endcase
		end
	end

endmodule

// File: verilog/video_pkg.sv
//////////////////////////////////////////////////
// video pattern package
// register map, colours, grid geometry and widths
//////////////////////////////////////////////////

package video_pkg;

	// widths
	localparam int coord_w = 10;
	localparam int cell_addr_w = 11;

	typedef logic [coord_w-1:0] coord_t;
	typedef logic [cell_addr_w-1:0] cell_addr_t;
	typedef logic [23:0] rgb_t;

	//////////////////////////////////////////////////
	// bridge register map
	localparam logic [31:0] addr_anim_en = 32'h0010_0000;
	localparam logic [31:0] addr_debug = 32'h0010_0004;
	localparam logic [31:0] addr_square_x = 32'h0020_0000;
	localparam logic [31:0] addr_square_y = 32'h0020_0004;
	localparam logic [31:0] addr_scratch = 32'h0030_0000;
	localparam logic [31:0] addr_cell_write = 32'h0040_0000;
	localparam logic [31:0] addr_chan_en = 32'h00F0_000C;
	// command addresses, write only
	localparam logic [31:0] addr_reset_square = 32'h00F0_0010;
	localparam logic [31:0] addr_reset_frame = 32'h00F0_0014;
	localparam logic [31:0] addr_incr_frame = 32'h00F0_0018;
	localparam logic [31:0] addr_frame_count = 32'h2000_0000;

	localparam logic [31:0] debug_reset_value = 32'h1200_5678;

	// colours
	localparam rgb_t black = 24'h000000;
	localparam rgb_t white = 24'hFFFFFF;
	localparam rgb_t red = 24'hFF0000;
	localparam rgb_t green = 24'h00FF00;
	localparam rgb_t blue = 24'h0000FF;
	localparam rgb_t magenta = 24'hFF00FF;

	// 8x8 pixel cells over 320x240
	localparam int grid_cols = 40;
	localparam int grid_rows = 30;
	localparam int grid_cells = grid_cols * grid_rows;
	localparam int cell_shift = 3;

	// cont1_key bits
	localparam int key_up = 0;
	localparam int key_down = 1;
	localparam int key_left = 2;
	localparam int key_right = 3;
	localparam int key_a = 4;
	localparam int key_b = 5;

endpackage
